//--- source/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// Words moved by one memory command
	localparam int burst_len = 32;

	// Depth of each accelerator staging FIFO
	localparam int fifo_depth = 1024;

	// Occupancy reported by an accelerator FIFO
	typedef logic [9:0] fifo_count_t;

	// Beats still to move in the current burst
	// Wide enough to hold burst_len itself
	typedef logic [5:0] beat_cnt_t;

	typedef enum logic [3:0] {
		idle,
		wr_req,
		wr_wait,
		wr_next,
		wr_cmd,
		rd_cmd,
		rd_req,
		rd_take,
		rd_next
	} dma_state_t;

endpackage

`default_nettype wire

//--- source/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

	typedef logic [31:0] word_t;

	typedef logic [29:0] byte_addr_t;

	// Instruction codes of the memory controller user port
	typedef enum logic [2:0] {
		mem_write = 3'd0,
		mem_read  = 3'd1
	} mem_instr_t;

	typedef struct packed {
		mem_instr_t instr;
		byte_addr_t byte_addr;
	} mem_cmd_t;

	// Address stride between bursts with four bytes per word
	localparam byte_addr_t burst_bytes = byte_addr_t'(4 * dma_pkg::burst_len);

endpackage

`default_nettype wire

//--- source/dma_burst_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dma_burst_ctrl (
	input  logic                 clk,
	input  logic                 reset_d,
	input  logic                 calib_done_i,
	input  logic                 writes_en_i,
	input  logic                 reads_en_i,
	input  dma_pkg::fifo_count_t ib_count_i,
	input  dma_pkg::fifo_count_t ob_count_i,
	input  logic                 ib_valid_i,
	input  logic                 wr_full_i,
	input  logic                 cmd_full_i,
	input  logic                 rd_empty_i,
	input  logic                 wr_last_i,
	input  logic                 rd_last_i,
	output logic                 wr_pop_o,
	output logic                 wr_take_o,
	output logic                 wr_issue_o,
	output logic                 rd_issue_o,
	output logic                 rd_pop_o,
	output logic                 rd_take_o
);
	import dma_pkg::*;

	dma_state_t state;
	dma_state_t state_nxt;
	logic       writes_q;
	logic       reads_q;
	logic       ib_seen;
	logic       wr_ready;
	logic       rd_ready;

	// A burst only starts once the FIFO can supply or absorb all of it
	assign wr_ready = calib_done_i && writes_q && (ib_count_i >= fifo_count_t'(burst_len));
	assign rd_ready = calib_done_i && reads_q &&
		(ob_count_i < fifo_count_t'(fifo_depth - 1 - burst_len));

	always_ff @(posedge clk) begin
		if (reset_d) begin
			state    <= idle;
			writes_q <= 1'b0;
			reads_q  <= 1'b0;
			ib_seen  <= 1'b0;
		end else begin
			state    <= state_nxt;
			writes_q <= writes_en_i;
			reads_q  <= reads_en_i;
			// Remember a valid word that arrived while the write FIFO was full
			if (wr_take_o) begin
				ib_seen <= 1'b0;
			end else if (state == wr_wait && ib_valid_i) begin
				ib_seen <= 1'b1;
			end
		end
	end

	always_comb begin
		state_nxt  = state;
		wr_pop_o   = 1'b0;
		wr_take_o  = 1'b0;
		wr_issue_o = 1'b0;
		rd_issue_o = 1'b0;
		rd_pop_o   = 1'b0;
		rd_take_o  = 1'b0;
		case (state)
			idle: begin
				if (wr_ready) begin
					state_nxt = wr_req;
				end else if (rd_ready) begin
					state_nxt = rd_cmd;
				end
			end
			wr_req: begin
				wr_pop_o  = 1'b1;
				state_nxt = wr_wait;
			end
			wr_wait: begin
				// The input buffer keeps its word on the output until the next pop
				if ((ib_valid_i || ib_seen) && !wr_full_i) begin
					wr_take_o = 1'b1;
					state_nxt = wr_next;
				end
			end
			wr_next: begin
				state_nxt = wr_last_i ? wr_cmd : wr_req;
			end
			wr_cmd: begin
				// Write data is already queued so the command closes the burst
				if (!cmd_full_i) begin
					wr_issue_o = 1'b1;
					state_nxt  = idle;
				end
			end
			rd_cmd: begin
				if (!cmd_full_i) begin
					rd_issue_o = 1'b1;
					state_nxt  = rd_req;
				end
			end
			rd_req: begin
				if (!rd_empty_i) begin
					rd_pop_o  = 1'b1;
					state_nxt = rd_take;
				end
			end
			rd_take: begin
				rd_take_o = 1'b1;
				state_nxt = rd_next;
			end
			rd_next: begin
				state_nxt = rd_last_i ? idle : rd_req;
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/dma_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dma_addr_gen (
	input  logic                   clk,
	input  logic                   reset_d,
	input  logic                   wr_issue_i,
	input  logic                   rd_issue_i,
	output logic                   cmd_en_o,
	output mem_port_pkg::mem_cmd_t cmd_o
);
	import mem_port_pkg::*;

	byte_addr_t wr_addr;
	byte_addr_t rd_addr;

	always_ff @(posedge clk) begin
		if (reset_d) begin
			cmd_en_o <= 1'b0;
			wr_addr  <= '0;
			rd_addr  <= '0;
		end else begin
			cmd_en_o <= wr_issue_i || rd_issue_i;
			if (wr_issue_i) begin
				wr_addr <= wr_addr + burst_bytes;
			end else if (rd_issue_i) begin
				rd_addr <= rd_addr + burst_bytes;
			end
		end
	end

	// Each direction walks its own ascending sequence of bursts
	always_ff @(posedge clk) begin
		if (wr_issue_i) begin
			cmd_o <= '{instr: mem_write, byte_addr: wr_addr};
		end else if (rd_issue_i) begin
			cmd_o <= '{instr: mem_read, byte_addr: rd_addr};
		end
	end

endmodule

`default_nettype wire

//--- source/dma_wr_path.sv
`timescale 1ns/100ps
`default_nettype none

module dma_wr_path (
	input  logic                clk,
	input  logic                reset_d,
	input  logic                wr_pop_i,
	input  logic                wr_take_i,
	input  mem_port_pkg::word_t ib_data_i,
	output logic                ib_re_o,
	output logic                wr_en_o,
	output mem_port_pkg::word_t wr_data_o,
	output logic                wr_last_o
);
	import dma_pkg::*;

	beat_cnt_t beats_left;

	assign wr_last_o = (beats_left == '0);

	always_ff @(posedge clk) begin
		if (reset_d) begin
			ib_re_o    <= 1'b0;
			wr_en_o    <= 1'b0;
			beats_left <= beat_cnt_t'(burst_len);
		end else begin
			ib_re_o <= wr_pop_i;
			wr_en_o <= wr_take_i;
			if (wr_take_i) begin
				beats_left <= beats_left - 1'b1;
			end else if (wr_last_o) begin
				// Ready for the next burst once the last word has gone out
				beats_left <= beat_cnt_t'(burst_len);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take_i) begin
			wr_data_o <= ib_data_i;
		end
	end

endmodule

`default_nettype wire

//--- source/dma_rd_path.sv
`timescale 1ns/100ps
`default_nettype none

module dma_rd_path (
	input  logic                clk,
	input  logic                reset_d,
	input  logic                rd_pop_i,
	input  logic                rd_take_i,
	input  mem_port_pkg::word_t rd_data_i,
	output logic                rd_en_o,
	output logic                ob_we_o,
	output mem_port_pkg::word_t ob_data_o,
	output logic                rd_last_o
);
	import dma_pkg::*;

	beat_cnt_t beats_left;
	logic      take_q;

	assign rd_last_o = (beats_left == '0);

	always_ff @(posedge clk) begin
		if (reset_d) begin
			rd_en_o    <= 1'b0;
			take_q     <= 1'b0;
			ob_we_o    <= 1'b0;
			beats_left <= beat_cnt_t'(burst_len);
		end else begin
			rd_en_o <= rd_pop_i;
			// Read data shows up one cycle behind the pop
			take_q  <= rd_take_i;
			ob_we_o <= take_q;
			if (rd_take_i) begin
				beats_left <= beats_left - 1'b1;
			end else if (rd_last_o) begin
				beats_left <= beat_cnt_t'(burst_len);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_q) begin
			ob_data_o <= rd_data_i;
		end
	end

endmodule

`default_nettype wire

//--- source/dma_top.sv
`timescale 1ns/100ps
`default_nettype none

module dma_top (
	input  logic                   clk,
	input  logic                   reset_d,
	input  logic                   calib_done_i,
	input  logic                   writes_en_i,
	input  logic                   reads_en_i,
	// Input buffer carrying accelerator results toward memory
	output logic                   ib_re_o,
	input  mem_port_pkg::word_t    ib_data_i,
	input  dma_pkg::fifo_count_t   ib_count_i,
	input  logic                   ib_valid_i,
	// Output buffer feeding operands to the accelerator
	output logic                   ob_we_o,
	output mem_port_pkg::word_t    ob_data_o,
	input  dma_pkg::fifo_count_t   ob_count_i,
	// Memory controller user port
	output logic                   cmd_en_o,
	output mem_port_pkg::mem_cmd_t cmd_o,
	input  logic                   cmd_full_i,
	output logic                   wr_en_o,
	output mem_port_pkg::word_t    wr_data_o,
	input  logic                   wr_full_i,
	output logic                   rd_en_o,
	input  mem_port_pkg::word_t    rd_data_i,
	input  logic                   rd_empty_i
);

	logic wr_pop;
	logic wr_take;
	logic wr_issue;
	logic wr_last;
	logic rd_pop;
	logic rd_take;
	logic rd_issue;
	logic rd_last;

	dma_burst_ctrl dma_burst_ctrl_i (
		.clk          (clk),
		.reset_d      (reset_d),
		.calib_done_i (calib_done_i),
		.writes_en_i  (writes_en_i),
		.reads_en_i   (reads_en_i),
		.ib_count_i   (ib_count_i),
		.ob_count_i   (ob_count_i),
		.ib_valid_i   (ib_valid_i),
		.wr_full_i    (wr_full_i),
		.cmd_full_i   (cmd_full_i),
		.rd_empty_i   (rd_empty_i),
		.wr_last_i    (wr_last),
		.rd_last_i    (rd_last),
		.wr_pop_o     (wr_pop),
		.wr_take_o    (wr_take),
		.wr_issue_o   (wr_issue),
		.rd_issue_o   (rd_issue),
		.rd_pop_o     (rd_pop),
		.rd_take_o    (rd_take)
	);

	dma_addr_gen dma_addr_gen_i (
		.clk        (clk),
		.reset_d    (reset_d),
		.wr_issue_i (wr_issue),
		.rd_issue_i (rd_issue),
		.cmd_en_o   (cmd_en_o),
		.cmd_o      (cmd_o)
	);

	dma_wr_path dma_wr_path_i (
		.clk       (clk),
		.reset_d   (reset_d),
		.wr_pop_i  (wr_pop),
		.wr_take_i (wr_take),
		.ib_data_i (ib_data_i),
		.ib_re_o   (ib_re_o),
		.wr_en_o   (wr_en_o),
		.wr_data_o (wr_data_o),
		.wr_last_o (wr_last)
	);

	dma_rd_path dma_rd_path_i (
		.clk       (clk),
		.reset_d   (reset_d),
		.rd_pop_i  (rd_pop),
		.rd_take_i (rd_take),
		.rd_data_i (rd_data_i),
		.rd_en_o   (rd_en_o),
		.ob_we_o   (ob_we_o),
		.ob_data_o (ob_data_o),
		.rd_last_o (rd_last)
	);

endmodule

`default_nettype wire

//--- verif/mem_port_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_port_model (
	input  wire logic                   clk,
	input  wire logic                   reset_d,
	input  wire logic                   cmd_en_i,
	input  wire mem_port_pkg::mem_cmd_t cmd_i,
	input  wire logic                   wr_en_i,
	input  wire mem_port_pkg::word_t    wr_data_i,
	input  wire logic                   rd_en_i,
	input  wire logic                   wr_stall_i,
	input  wire logic                   cmd_stall_i,
	input  wire logic                   rd_stall_i,
	output logic                        cmd_full_o,
	output logic                        wr_full_o,
	output logic                        rd_empty_o,
	output mem_port_pkg::word_t         rd_data_o
);
	import dma_pkg::*;
	import mem_port_pkg::*;

	word_t    mem [0:1023];
	word_t    wr_q[$];
	word_t    rd_q[$];
	mem_cmd_t cmd_q[$];
	logic     rd_has;

	// The queues never fill, so full flags only come from the stall inputs
	assign cmd_full_o = cmd_stall_i;
	assign wr_full_o  = wr_stall_i;
	assign rd_empty_o = !rd_has || rd_stall_i;

	always @(posedge clk) begin
		mem_cmd_t   c;
		logic [9:0] idx;
		if (reset_d) begin
			wr_q.delete();
			rd_q.delete();
			cmd_q.delete();
			rd_has <= 1'b0;
		end else begin
			if (wr_en_i) begin
				wr_q.push_back(wr_data_i);
			end
			if (rd_en_i) begin
				rd_data_o <= rd_q.pop_front();
			end
			// One queued command is executed per cycle as a whole burst
			if (cmd_q.size() > 0) begin
				c = cmd_q.pop_front();
				idx = c.byte_addr[11:2];
				for (int i = 0; i < burst_len; i++) begin
					if (c.instr == mem_write) begin
						mem[idx + 10'(i)] = wr_q.pop_front();
					end else begin
						rd_q.push_back(mem[idx + 10'(i)]);
					end
				end
			end
			if (cmd_en_i) begin
				cmd_q.push_back(cmd_i);
			end
			rd_has <= (rd_q.size() != 0);
		end
	end

endmodule

`default_nettype wire

//--- verif/dma_sva.sv
`timescale 1ns/100ps
`default_nettype none

module dma_sva (
	input wire logic clk,
	input wire logic reset_d,
	input wire logic wr_en_o,
	input wire logic wr_full_i,
	input wire logic cmd_en_o,
	input wire logic cmd_full_i,
	input wire logic rd_en_o,
	input wire logic rd_empty_i
);

	// Each push must follow a cycle in which the controller reported room
	wr_after_full: assert property (@(posedge clk) disable iff (reset_d)
		wr_en_o |-> !$past(wr_full_i))
		else $error("write FIFO push after the full flag was set");

	cmd_after_full: assert property (@(posedge clk) disable iff (reset_d)
		cmd_en_o |-> !$past(cmd_full_i))
		else $error("command issued after the command FIFO was full");

	rd_when_empty: assert property (@(posedge clk) disable iff (reset_d)
		rd_en_o |-> !$past(rd_empty_i))
		else $error("read FIFO pop while it was empty");

endmodule

bind dma_top dma_sva dma_sva_i (
	.clk        (clk),
	.reset_d    (reset_d),
	.wr_en_o    (wr_en_o),
	.wr_full_i  (wr_full_i),
	.cmd_en_o   (cmd_en_o),
	.cmd_full_i (cmd_full_i),
	.rd_en_o    (rd_en_o),
	.rd_empty_i (rd_empty_i)
);

`default_nettype wire

//--- verif/dma_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dma_tb;
	import dma_pkg::*;
	import mem_port_pkg::*;

	localparam int bursts = 8;
	localparam int limit_cycles = bursts * burst_len * 12 + 2000;

	logic        clk;
	logic        reset_d;
	logic        calib_done_i;
	logic        writes_en_i;
	logic        reads_en_i;
	logic        ib_re_o;
	logic        ib_valid_i;
	word_t       ib_data_i;
	fifo_count_t ib_count_i;
	fifo_count_t ob_count_i;
	logic        ob_we_o;
	word_t       ob_data_o;
	logic        cmd_en_o;
	mem_cmd_t    cmd_o;
	logic        cmd_full_i;
	logic        wr_en_o;
	word_t       wr_data_o;
	logic        wr_full_i;
	logic        rd_en_o;
	word_t       rd_data_i;
	logic        rd_empty_i;
	logic        wr_stall;
	logic        cmd_stall;
	logic        rd_stall;
	logic        stall_on;
	logic        write_phase;
	logic        threshold_phase;
	logic [31:0] lfsr_state;
	logic        ib_pend;
	int          ib_wait;
	word_t       ib_next;
	word_t       pushed[$];
	int          ib_pops;
	int          ob_words;
	int          wr_cmds;
	int          rd_cmds;

	dma_top dma_top_i (
		.clk          (clk),
		.reset_d      (reset_d),
		.calib_done_i (calib_done_i),
		.writes_en_i  (writes_en_i),
		.reads_en_i   (reads_en_i),
		.ib_re_o      (ib_re_o),
		.ib_data_i    (ib_data_i),
		.ib_count_i   (ib_count_i),
		.ib_valid_i   (ib_valid_i),
		.ob_we_o      (ob_we_o),
		.ob_data_o    (ob_data_o),
		.ob_count_i   (ob_count_i),
		.cmd_en_o     (cmd_en_o),
		.cmd_o        (cmd_o),
		.cmd_full_i   (cmd_full_i),
		.wr_en_o      (wr_en_o),
		.wr_data_o    (wr_data_o),
		.wr_full_i    (wr_full_i),
		.rd_en_o      (rd_en_o),
		.rd_data_i    (rd_data_i),
		.rd_empty_i   (rd_empty_i)
	);

	mem_port_model model_i (
		.clk         (clk),
		.reset_d     (reset_d),
		.cmd_en_i    (cmd_en_o),
		.cmd_i       (cmd_o),
		.wr_en_i     (wr_en_o),
		.wr_data_i   (wr_data_o),
		.rd_en_i     (rd_en_o),
		.wr_stall_i  (wr_stall),
		.cmd_stall_i (cmd_stall),
		.rd_stall_i  (rd_stall),
		.cmd_full_o  (cmd_full_i),
		.wr_full_o   (wr_full_i),
		.rd_empty_o  (rd_empty_i),
		.rd_data_o   (rd_data_i)
	);

	// Galois LFSR stepped once per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (fb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Contents that the memory holds before the read bursts
	function automatic word_t mem_word(input byte_addr_t a);
		return ({2'b00, a} * 32'h9E37_79B1) ^ 32'h3C5A_96E1;
	endfunction

	function automatic mem_cmd_t cmd_ref(input mem_instr_t instr, input int n);
		mem_cmd_t c;
		c.instr = instr;
		c.byte_addr = byte_addr_t'(n * 4 * burst_len);
		return c;
	endfunction

	task automatic stop_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_cmd(input string name, input mem_cmd_t got, input mem_cmd_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%09h expected 0x%09h", name, got, exp);
			stop_run();
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the DUT stopped making progress");
		$display("test failed");
		$fatal(1);
	end

	// Input buffer answers each pop after a random delay and back-pressure flags
	always @(posedge clk) begin
		if (reset_d) begin
			ib_valid_i <= 1'b0;
			wr_stall   <= 1'b0;
			cmd_stall  <= 1'b0;
			rd_stall   <= 1'b0;
			ib_pend    = 1'b0;
		end else begin
			ib_valid_i <= 1'b0;
			if (ib_pend) begin
				if (ib_wait == 0) begin
					ib_next = rand_bits(32);
					ib_data_i  <= ib_next;
					ib_valid_i <= 1'b1;
					pushed.push_back(ib_next);
					ib_pend = 1'b0;
				end else begin
					ib_wait--;
				end
			end
			if (ib_re_o) begin
				ib_pend = 1'b1;
				ib_wait = int'(rand_bits(2));
			end
			if (stall_on) begin
				wr_stall  <= (rand_bits(2) == 0);
				cmd_stall <= (rand_bits(2) == 0);
				rd_stall  <= (rand_bits(2) == 0);
			end else begin
				wr_stall  <= 1'b0;
				cmd_stall <= 1'b0;
				rd_stall  <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (reset_d || !calib_done_i) begin
			if (ib_re_o || ob_we_o || cmd_en_o || wr_en_o || rd_en_o) begin
				fail_now("a strobe output pulsed during reset or before calibration");
			end
		end else begin
			if (ib_re_o) begin
				ib_pops++;
			end
			if (ob_we_o) begin
				check_word("ob_data_o", ob_data_o, mem_word(byte_addr_t'(4 * ob_words)));
				ob_words++;
			end
			if (cmd_en_o) begin
				if (threshold_phase) begin
					fail_now("a read started with the output buffer at the threshold");
				end
				if (write_phase) begin
					check_cmd("cmd_o", cmd_o, cmd_ref(mem_write, wr_cmds));
					wr_cmds++;
				end else begin
					if (ob_words != burst_len * rd_cmds) begin
						fail_now("a read burst did not deliver exactly 32 words");
					end
					check_cmd("cmd_o", cmd_o, cmd_ref(mem_read, rd_cmds));
					rd_cmds++;
				end
			end
		end
	end

	initial begin
		lfsr_state = 32'd72;
		reset_d = 1'b1;
		calib_done_i = 1'b0;
		writes_en_i = 1'b0;
		reads_en_i = 1'b0;
		ib_valid_i = 1'b0;
		ib_data_i = '0;
		ib_count_i = '0;
		ob_count_i = '0;
		wr_stall = 1'b0;
		cmd_stall = 1'b0;
		rd_stall = 1'b0;
		stall_on = 1'b0;
		write_phase = 1'b1;
		threshold_phase = 1'b0;
		ib_pops = 0;
		ob_words = 0;
		wr_cmds = 0;
		rd_cmds = 0;
		repeat (8) @(posedge clk);
		reset_d <= 1'b0;

		// Everything asks for work but calibration is still pending
		writes_en_i <= 1'b1;
		reads_en_i  <= 1'b1;
		ib_count_i  <= fifo_count_t'(1000);
		repeat (100) @(posedge clk);
		calib_done_i <= 1'b1;

		// Reads are also possible here, so each command must be a write
		while (wr_cmds < 2) @(negedge clk);
		@(posedge clk);
		stall_on <= 1'b1;
		while (wr_cmds < 4) @(negedge clk);
		@(posedge clk);
		writes_en_i <= 1'b0;
		reads_en_i  <= 1'b0;
		repeat (3) @(negedge clk);
		while (ib_pops != burst_len * wr_cmds) @(negedge clk);
		repeat (8) @(negedge clk);
		if (pushed.size() != burst_len * wr_cmds) begin
			fail_now("input buffer words do not match the write bursts");
		end
		for (int j = 0; j < burst_len * wr_cmds; j++) begin
			check_word("model_i.mem", model_i.mem[j], pushed[j]);
		end

		for (int j = 0; j < 1024; j++) begin
			model_i.mem[j] = mem_word(byte_addr_t'(4 * j));
		end
		@(posedge clk);
		stall_on        <= 1'b0;
		write_phase     <= 1'b0;
		threshold_phase <= 1'b1;
		ob_count_i      <= fifo_count_t'(fifo_depth - 1 - burst_len);
		reads_en_i      <= 1'b1;
		repeat (200) @(posedge clk);
		threshold_phase <= 1'b0;
		ob_count_i      <= fifo_count_t'(fifo_depth - 2 - burst_len);

		while (rd_cmds < 2) @(negedge clk);
		@(posedge clk);
		stall_on <= 1'b1;
		while (rd_cmds < 4) @(negedge clk);
		@(posedge clk);
		reads_en_i <= 1'b0;
		repeat (3) @(negedge clk);
		while (ob_words != burst_len * rd_cmds) @(negedge clk);
		repeat (8) @(negedge clk);
		if (ob_words != burst_len * rd_cmds) begin
			fail_now("a read burst did not deliver exactly 32 words");
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
source/dma_pkg.sv
source/mem_port_pkg.sv
source/dma_burst_ctrl.sv
source/dma_addr_gen.sv
source/dma_wr_path.sv
source/dma_rd_path.sv
source/dma_top.sv
verif/mem_port_model.sv
verif/dma_sva.sv
verif/dma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dma_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
